// File: Makefile
# Verilator build and run for the SPI slave testbench.

VERILATOR ?= verilator
TOP       ?= spi_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= verilog.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN) dv/spi_trace.txt
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/spi_checker.sv
/* SPI slave checker: assembles MISO words, checks host reads,
   write buffer state and the idle state after reset. */

`timescale 1ns/1ps

module spi_checker (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               sck,
   input  logic                               ss,
   input  logic                               miso,
   input  logic                               wr_buffer_free,
   input  logic                               rd_ack,
   input  logic [spi_pkg::payload_bits_c-1:0] rd_data,
   input  logic                               rd_data_available,
   input  int                                 frame_idx,
   input  logic [spi_pkg::frame_bits_c-1:0]   exp_miso,
   input  logic                               exp_host_used,
   input  logic                               exp_rd_used,
   input  logic [spi_pkg::payload_bits_c-1:0] exp_rd,
   output int                                 error_count
);
   import spi_pkg::*;

   logic                    sck_q;
   logic                    ss_q;
   logic                    avail_q;
   logic                    ack_q;
   logic                    reset_q;
   logic [frame_bits_c-1:0] miso_word;
   int                      bit_count;
   int                      errors = 0;

   // The master samples MISO on SCK rising, so the word is built the same way.
   always @(posedge clk) begin
      sck_q   <= sck;
      ss_q    <= ss;
      avail_q <= rd_data_available;
      ack_q   <= rd_ack;
      reset_q <= reset;
      if (!reset) begin
         if (reset_q) begin
            if (wr_buffer_free !== 1'b1) begin
               $display("** Error: wr_buffer_free after reset got 0x%0h expected 0x1",
                        wr_buffer_free);
               errors = errors + 1;
            end
            if (rd_data_available !== 1'b0) begin
               $display("** Error: rd_data_available after reset got 0x%0h expected 0x0",
                        rd_data_available);
               errors = errors + 1;
            end
            if (miso !== 1'b0) begin
               $display("** Error: miso after reset got 0x%0h expected 0x0", miso);
               errors = errors + 1;
            end
         end
         if (!ss && ss_q) bit_count <= 0; // Frame start.
         if (sck && !sck_q && !ss) begin
            miso_word <= {miso, miso_word[frame_bits_c-1:1]};
            bit_count <= bit_count + 1;
         end
         if (ss && !ss_q) begin
            if (bit_count != frame_bits_c) begin
               $display("Frame %0d ended after %0d SCK rising edges instead of %0d",
                        frame_idx, bit_count, frame_bits_c);
               errors = errors + 1;
            end else if (miso_word !== exp_miso) begin
               $display("** Error: frame %0d miso word got 0x%08h expected 0x%08h",
                        frame_idx, miso_word, exp_miso);
               errors = errors + 1;
            end
            if (exp_host_used && wr_buffer_free !== 1'b1) begin
               $display("** Error: frame %0d wr_buffer_free got 0x%0h expected 0x1",
                        frame_idx, wr_buffer_free);
               errors = errors + 1;
            end
         end
         if (rd_data_available && !avail_q) begin
            if (!exp_rd_used) begin
               $display("Read data became available in frame %0d with no read expected",
                        frame_idx);
               errors = errors + 1;
            end else if (rd_data !== exp_rd) begin
               $display("** Error: frame %0d rd_data got 0x%06h expected 0x%06h",
                        frame_idx, rd_data, exp_rd);
               errors = errors + 1;
            end
         end
         if (rd_ack && rd_data !== exp_rd) begin
            $display("** Error: frame %0d rd_data at rd_ack got 0x%06h expected 0x%06h",
                     frame_idx, rd_data, exp_rd);
            errors = errors + 1;
         end
         // Read data is held until the host acknowledges it and drops right after.
         if (avail_q && !rd_data_available && !ack_q) begin
            $display("Read data in frame %0d was withdrawn before the host acknowledged it",
                     frame_idx);
            errors = errors + 1;
         end
         if (ack_q && rd_data_available !== 1'b0) begin
            $display("** Error: frame %0d rd_data_available got 0x%0h expected 0x0",
                     frame_idx, rd_data_available);
            errors = errors + 1;
         end
      end
   end

   assign error_count = errors;

endmodule

// File: dv/spi_tb.sv
/* SPI slave testbench top: trace reader, SPI master and host model,
   DUT, clock generator and checker. */

`timescale 1ns/1ps

module spi_tb;
   import spi_pkg::*;

   localparam int max_frames_c  = 32;
   localparam int fields_c      = 7;    // Values per trace line.
   localparam int half_sck_c    = 8;    // clk cycles per SCK half period.
   localparam int frame_gap_c   = 20;
   localparam int wait_limit_c  = 2000;
   localparam int sel_reset_c   = 0;
   localparam int sel_free_c    = 1;
   localparam int sel_avail_c   = 2;

   logic                      clk;
   logic                      reset;
   logic                      sck;
   logic                      ss;
   logic                      mosi;
   logic                      miso;
   logic                      wr_en;
   logic [payload_bits_c-1:0] wr_data;
   logic                      wr_buffer_free;
   logic                      rd_ack;
   logic [payload_bits_c-1:0] rd_data;
   logic                      rd_data_available;
   logic [31:0]               trace_mem [0:fields_c*max_frames_c];
   int                        frame_idx;
   logic [frame_bits_c-1:0]   exp_miso;
   logic                      exp_host_used;
   logic                      exp_rd_used;
   logic [payload_bits_c-1:0] exp_rd;
   int                        error_count;
   logic                      aborted;

   tb_clock tb_clock_inst (.clk(clk), .reset(reset));

   spi_slave_top spi_slave_top_inst (
      .clk(clk), .reset(reset), .sck(sck), .ss(ss), .mosi(mosi), .miso(miso),
      .wr_en(wr_en), .wr_data(wr_data), .wr_buffer_free(wr_buffer_free),
      .rd_ack(rd_ack), .rd_data(rd_data), .rd_data_available(rd_data_available)
   );

   spi_checker spi_checker_inst (
      .clk(clk), .reset(reset), .sck(sck), .ss(ss), .miso(miso),
      .wr_buffer_free(wr_buffer_free), .rd_ack(rd_ack), .rd_data(rd_data),
      .rd_data_available(rd_data_available), .frame_idx(frame_idx), .exp_miso(exp_miso),
      .exp_host_used(exp_host_used), .exp_rd_used(exp_rd_used), .exp_rd(exp_rd),
      .error_count(error_count)
   );

   function automatic logic probe(input int sel);
      case (sel)
         sel_reset_c: probe = reset;
         sel_free_c:  probe = wr_buffer_free;
         default:     probe = rd_data_available;
      endcase
   endfunction

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge clk);
   endtask

   task automatic wait_level(input int sel, input logic level, input string what);
      int cycles;
      cycles = 0;
      while (!aborted && probe(sel) !== level) begin
         @(negedge clk);
         cycles = cycles + 1;
         if (cycles >= wait_limit_c) begin
            $display("Timed out after %0d cycles waiting for %s in frame %0d",
                     cycles, what, frame_idx);
            aborted = 1'b1;
         end
      end
   endtask

   task automatic host_write(input logic [payload_bits_c-1:0] word);
      wait_level(sel_free_c, 1'b1, "wr_buffer_free");
      if (!aborted) begin
         wr_en   = 1'b1;
         wr_data = word;
         @(negedge clk);
         wr_en   = 1'b0;
      end
   endtask

   // The mode 0 master changes MOSI while SCK is low and sends the LSB first.
   task automatic send_frame(input logic [frame_bits_c-1:0] frame);
      int i;
      ss = 1'b0;
      idle(half_sck_c);
      for (i = 0; i < frame_bits_c; i++) begin
         mosi = frame[i];
         idle(half_sck_c);
         sck = 1'b1;
         idle(half_sck_c);
         sck = 1'b0;
      end
      idle(half_sck_c);
      ss   = 1'b1;
      mosi = 1'b0;
   endtask

   task automatic host_read(input logic rd_used, input logic skip_ack);
      if (rd_used) begin
         wait_level(sel_avail_c, 1'b1, "rd_data_available");
         if (!skip_ack && !aborted) begin
            rd_ack = 1'b1;
            @(negedge clk);
            rd_ack = 1'b0;
            wait_level(sel_avail_c, 1'b0, "rd_data_available to drop");
         end
      end
   endtask

   initial begin
      int n_frames;
      int base;
      int f;
      sck           = 1'b0;
      ss            = 1'b1;
      mosi          = 1'b0;
      wr_en         = 1'b0;
      wr_data       = '0;
      rd_ack        = 1'b0;
      aborted       = 1'b0;
      frame_idx     = 0;
      exp_miso      = '0;
      exp_host_used = 1'b0;
      exp_rd_used   = 1'b0;
      exp_rd        = '0;
      $readmemh("dv/spi_trace.txt", trace_mem);
      n_frames = trace_mem[0];
      if (n_frames < 1 || n_frames > max_frames_c) begin
         $display("Trace file gives an unusable frame count of %0d", n_frames);
         aborted = 1'b1;
      end
      wait_level(sel_reset_c, 1'b0, "reset release");
      idle(frame_gap_c);
      for (f = 0; f < n_frames && !aborted; f++) begin
         base      = 1 + f * fields_c;
         frame_idx = f;
         if (trace_mem[base][0]) host_write(trace_mem[base+1][payload_bits_c-1:0]);
         exp_host_used = trace_mem[base][0];
         exp_miso      = trace_mem[base+3];
         exp_rd_used   = trace_mem[base+4][0];
         exp_rd        = trace_mem[base+5][payload_bits_c-1:0];
         send_frame(trace_mem[base+2]);
         host_read(trace_mem[base+4][0], trace_mem[base+6][0]);
         idle(frame_gap_c);
      end
      $display("Frames run: %0d, errors: %0d, aborted: %0d", f, error_count, aborted);
      if (aborted || error_count != 0) begin
         $display("TEST RESULT: FAIL");
      end else begin
         $display("TEST RESULT: PASS");
      end
      $finish;
   end

endmodule

// File: dv/spi_trace.txt
// Columns: host_used host_word mosi_frame exp_miso rd_used exp_rd skip_ack (all hex).
// The first value is the number of frames that follow.
11
0 000000 00000000 00000000 0 000000 0
1 A5C3E1 12345601 A5C3E101 1 123456 0
0 000000 00FFEE00 A5C3E100 0 000000 0
0 000000 0BEEF101 A5C3E100 1 0BEEF1 1
0 000000 77777701 A5C3E100 1 0BEEF1 1
0 000000 00000000 A5C3E102 1 0BEEF1 0
0 000000 3C5A6902 A5C3E100 0 000000 0
0 000000 00000000 3C5A6900 0 000000 0
0 000000 1122337F 3C5A6900 0 000000 0
0 000000 00000000 3C5A6904 0 000000 0
0 000000 00000000 3C5A6900 0 000000 0
0 000000 44556602 3C5A6900 0 000000 0
1 0F1E2D 00000000 0F1E2D01 0 000000 0
0 000000 00000000 44556600 0 000000 0
0 000000 00000000 44556600 0 000000 0
1 00BEAD ABCDEF01 00BEAD01 1 ABCDEF 0
0 000000 00000000 00BEAD00 0 000000 0

// File: dv/tb_clock.sv
/* Testbench clock and synchronous reset generator. */

`timescale 1ns/1ps

module tb_clock #(
   parameter int half_period_ns = 4,
   parameter int reset_cycles   = 16
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(half_period_ns) clk = ~clk;
   end

   // Reset drops on a falling edge, away from the sampling edge.
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: hdl/spi_frame_ctrl.sv
/* Frame controller: opcode decode, host read and write buffers,
   status flags and selection of the next response word. */

`timescale 1ns/1ps

module spi_frame_ctrl (
   input  logic                               clk,
   input  logic                               reset,
   input  spi_pkg::spi_frame_t                rx_frame,
   input  logic                               rx_valid,
   input  logic                               tx_loaded_ack,
   input  logic                               wr_en,
   input  logic [spi_pkg::payload_bits_c-1:0] wr_data,
   output logic                               wr_buffer_free,
   input  logic                               rd_ack,
   output logic [spi_pkg::payload_bits_c-1:0] rd_data,
   output logic                               rd_data_available,
   output spi_pkg::tx_word_t                  next_tx
);
   import spi_pkg::*;

   logic                      host_full;
   logic [payload_bits_c-1:0] host_word;
   logic                      echo_pending;
   logic [payload_bits_c-1:0] echo_word;
   logic [payload_bits_c-1:0] last_payload;
   logic                      rd_avail_q;
   logic [payload_bits_c-1:0] rd_data_q;
   logic                      overrun_q;
   logic                      bad_op_q;
   status_t                   status;

   always_ff @(posedge clk) begin
      if (wr_en && !host_full) host_word <= wr_data;
      if (rx_valid && rx_frame.opcode == op_echo) echo_word <= rx_frame.payload;
      if (rx_valid && rx_frame.opcode == op_data && !rd_avail_q) begin
         rd_data_q <= rx_frame.payload;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         host_full    <= 1'b0;
         echo_pending <= 1'b0;
         last_payload <= '0;
         rd_avail_q   <= 1'b0;
         overrun_q    <= 1'b0;
         bad_op_q     <= 1'b0;
      end else begin
         if (wr_en && !host_full) host_full <= 1'b1;
         if (rd_ack) rd_avail_q <= 1'b0;
         // The shifter took the word, so retire its source and the reported flags.
         if (tx_loaded_ack) begin
            overrun_q <= 1'b0;
            bad_op_q  <= 1'b0;
            if (host_full) begin
               host_full    <= 1'b0;
               last_payload <= host_word;
            end else if (echo_pending) begin
               echo_pending <= 1'b0;
               last_payload <= echo_word;
            end
         end
         if (rx_valid) begin
            case (rx_frame.opcode)
               op_nop: ;
               op_data: begin
                  if (rd_avail_q) overrun_q <= 1'b1; // Host has not read the last one.
                  else rd_avail_q <= 1'b1;
               end
               op_echo: echo_pending <= 1'b1;
               default: bad_op_q <= 1'b1;
            endcase
         end
      end
   end

   always_comb begin
      status            = '0;
      status.tx_loaded  = host_full;
      status.rx_overrun = overrun_q;
      status.bad_opcode = bad_op_q;
      next_tx.status    = status;
      // Host word first, then a pending echo, else repeat what went out last.
      if (host_full) next_tx.payload = host_word;
      else if (echo_pending) next_tx.payload = echo_word;
      else next_tx.payload = last_payload;
   end

   assign wr_buffer_free    = ~host_full;
   assign rd_data           = rd_data_q;
   assign rd_data_available = rd_avail_q;

endmodule

// File: hdl/spi_pin_sync.sv
/* Pin synchronizers for SCK, SS and MOSI with edge pulses. */

`timescale 1ns/1ps

module spi_pin_sync (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 sck,
   input  logic                 ss,
   input  logic                 mosi,
   output spi_pkg::pin_events_t events
);
   import spi_pkg::*;

   // The top bit of the SCK and SS chains holds the previous synchronized value.
   logic [sync_stages_c:0]   sck_sr;
   logic [sync_stages_c:0]   ss_sr;
   logic [sync_stages_c-1:0] mosi_sr;

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sr  <= '0;
         ss_sr   <= '1; // Slave select idles high.
         mosi_sr <= '0;
      end else begin
         sck_sr  <= {sck_sr[sync_stages_c-1:0], sck};
         ss_sr   <= {ss_sr[sync_stages_c-1:0], ss};
         mosi_sr <= {mosi_sr[sync_stages_c-2:0], mosi};
      end
   end

   assign events.sck_rise  = sck_sr[sync_stages_c-1] & ~sck_sr[sync_stages_c];
   assign events.sck_fall  = ~sck_sr[sync_stages_c-1] & sck_sr[sync_stages_c];
   assign events.ss_fall   = ~ss_sr[sync_stages_c-1] & ss_sr[sync_stages_c];
   assign events.ss_rise   = ss_sr[sync_stages_c-1] & ~ss_sr[sync_stages_c];
   assign events.ss_active = ~ss_sr[sync_stages_c-1];
   assign events.mosi      = mosi_sr[sync_stages_c-1];

endmodule

// File: hdl/spi_pkg.sv
/* Shared SPI slave definitions: frame sizes, opcode enum, status byte,
   frame and response word layouts, and synchronized pin events. */

package spi_pkg;

   localparam int frame_bits_c   = 32;
   localparam int payload_bits_c = 24;
   localparam int cnt_bits_c     = $clog2(frame_bits_c);
   localparam int sync_stages_c  = 2; // Flops in front of each pin before edge detection.

   typedef enum logic [7:0] {
      op_nop  = 8'h00,
      op_data = 8'h01,
      op_echo = 8'h02
   } opcode_e;

   // Status byte returned in the low byte of every response.
   typedef struct packed {
      logic [4:0] reserved;
      logic       bad_opcode;
      logic       rx_overrun;
      logic       tx_loaded;
   } status_t;

   typedef struct packed {
      logic [payload_bits_c-1:0] payload;
      logic [7:0]                opcode;
   } spi_frame_t;

   typedef struct packed {
      logic [payload_bits_c-1:0] payload;
      status_t                   status;
   } tx_word_t;

   typedef struct packed {
      logic sck_rise;
      logic sck_fall;
      logic ss_fall;
      logic ss_rise;
      logic ss_active;
      logic mosi;
   } pin_events_t;

endpackage

// File: hdl/spi_rx_shifter.sv
/* Receive shifter: collects MOSI bits LSB first into a 32-bit frame. */

`timescale 1ns/1ps

module spi_rx_shifter (
   input  logic                 clk,
   input  logic                 reset,
   input  spi_pkg::pin_events_t events,
   output spi_pkg::spi_frame_t  rx_frame,
   output logic                 rx_valid
);
   import spi_pkg::*;

   logic [frame_bits_c-1:0] shift_q;
   logic [cnt_bits_c-1:0]   bit_cnt;
   logic                    valid_q;

   // New bits enter at the MSB, so the first bit ends up in bit 0.
   always_ff @(posedge clk) begin
      if (events.sck_rise && events.ss_active) begin
         shift_q <= {events.mosi, shift_q[frame_bits_c-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         if (events.ss_fall || events.ss_rise) begin
            bit_cnt <= '0; // A partial frame is thrown away here.
         end else if (events.sck_rise && events.ss_active) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == cnt_bits_c'(frame_bits_c - 1)) begin
               valid_q <= 1'b1;
            end
         end
      end
   end

   assign rx_frame = shift_q;
   assign rx_valid = valid_q;

endmodule

// File: hdl/spi_slave_top.sv
/* SPI slave top: pin synchronizer, receive and transmit shifters,
   and frame controller. */

`timescale 1ns/1ps

module spi_slave_top (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               sck,
   input  logic                               ss,
   input  logic                               mosi,
   output logic                               miso,
   input  logic                               wr_en,
   input  logic [spi_pkg::payload_bits_c-1:0] wr_data,
   output logic                               wr_buffer_free,
   input  logic                               rd_ack,
   output logic [spi_pkg::payload_bits_c-1:0] rd_data,
   output logic                               rd_data_available
);
   import spi_pkg::*;

   pin_events_t events;
   spi_frame_t  rx_frame;
   logic        rx_valid;
   tx_word_t    next_tx;
   logic        tx_loaded_ack;

   spi_pin_sync spi_pin_sync_inst (
      .clk    (clk),
      .reset  (reset),
      .sck    (sck),
      .ss     (ss),
      .mosi   (mosi),
      .events (events)
   );

   spi_rx_shifter spi_rx_shifter_inst (
      .clk      (clk),
      .reset    (reset),
      .events   (events),
      .rx_frame (rx_frame),
      .rx_valid (rx_valid)
   );

   spi_tx_shifter spi_tx_shifter_inst (
      .clk           (clk),
      .reset         (reset),
      .events        (events),
      .next_tx       (next_tx),
      .miso          (miso),
      .tx_loaded_ack (tx_loaded_ack)
   );

   spi_frame_ctrl spi_frame_ctrl_inst (
      .clk               (clk),
      .reset             (reset),
      .rx_frame          (rx_frame),
      .rx_valid          (rx_valid),
      .tx_loaded_ack     (tx_loaded_ack),
      .wr_en             (wr_en),
      .wr_data           (wr_data),
      .wr_buffer_free    (wr_buffer_free),
      .rd_ack            (rd_ack),
      .rd_data           (rd_data),
      .rd_data_available (rd_data_available),
      .next_tx           (next_tx)
   );

endmodule

// File: hdl/spi_tx_shifter.sv
/* Transmit shifter: loads the response at frame start and drives MISO. */

`timescale 1ns/1ps

module spi_tx_shifter (
   input  logic                 clk,
   input  logic                 reset,
   input  spi_pkg::pin_events_t events,
   input  spi_pkg::tx_word_t    next_tx,
   output logic                 miso,
   output logic                 tx_loaded_ack
);
   import spi_pkg::*;

   logic [frame_bits_c-1:0] tx_q;
   logic                    miso_q;
   logic                    ack_q;

   always_ff @(posedge clk) begin
      if (events.ss_fall) begin
         tx_q <= next_tx;
      end else if (events.sck_fall && events.ss_active) begin
         tx_q <= {1'b0, tx_q[frame_bits_c-1:1]};
      end
   end

   // MISO holds the current bit, tx_q[1] is the one after it.
   always_ff @(posedge clk) begin
      if (reset) begin
         miso_q <= 1'b0;
         ack_q  <= 1'b0;
      end else begin
         ack_q <= events.ss_fall;
         if (events.ss_fall) begin
            miso_q <= next_tx[0];
         end else if (!events.ss_active) begin
            miso_q <= 1'b0;
         end else if (events.sck_fall) begin
            miso_q <= tx_q[1];
         end
      end
   end

   assign miso          = miso_q;
   assign tx_loaded_ack = ack_q;

endmodule

// File: verilog.f
hdl/spi_pkg.sv
hdl/spi_pin_sync.sv
hdl/spi_rx_shifter.sv
hdl/spi_tx_shifter.sv
hdl/spi_frame_ctrl.sv
hdl/spi_slave_top.sv
dv/tb_clock.sv
dv/spi_checker.sv
dv/spi_tb.sv
